/* hdl/cavlc_defines.svh */
// CAVLC run decoder parameters
`ifndef CAVLC_DEFINES_SVH
`define CAVLC_DEFINES_SVH

// coefficients in one 4x4 block
`define CAVLC_NCOEF 16

// signed level width as delivered by the level decoder
`define CAVLC_LEVEL_W 9

// zero run and zeros_left width
`define CAVLC_RUN_W 4

// bitstream window, two 16-bit words
`define CAVLC_WIN_W 32

`endif

/* hdl/cavlc_pkg.sv */
// CAVLC run decoder types
`default_nettype none

`include "cavlc_defines.svh"

package cavlc_pkg;

	// coefficient level, two's complement
	typedef logic signed [`CAVLC_LEVEL_W-1:0] level_t;

	// run_before value or zeros count
	typedef logic [`CAVLC_RUN_W-1:0] run_t;

	// index into the block, scan order
	typedef logic [$clog2(`CAVLC_NCOEF)-1:0] pos_t;

	// TotalCoeff, 0 to 16
	typedef logic [$clog2(`CAVLC_NCOEF + 1)-1:0] tcoef_t;

	//------------------------------------------------------------
	// block sequencer states
	//------------------------------------------------------------
	typedef enum logic [2:0] {
		S_IDLE,
		S_CLEAR,
		S_RUN_LUT,
		S_RUN_SHIFT,
		S_LAST_RUN,
		S_PLACE,
		S_DONE
	} seq_state_t;

endpackage

`default_nettype wire

/* hdl/mem_port_if.sv */
// Coefficient store master port
`default_nettype none

interface mem_port_if #(
	parameter type payload_t = cavlc_pkg::level_t
) ();
	import cavlc_pkg::*;

	logic     req;
	logic     we;
	pos_t     addr;
	payload_t wdata;
	logic     gnt;
	payload_t rdata;

	// requester side
	modport master (
		output req, we, addr, wdata,
		input  gnt, rdata
	);

	// arbiter side
	modport slave (
		input  req, we, addr, wdata,
		output gnt, rdata
	);

endinterface

`default_nettype wire

/* hdl/bit_window.sv */
// MSB-first bitstream window
`default_nettype none

`include "cavlc_defines.svh"

module bit_window (
	input  logic             clk,
	input  logic             reset_n,
	input  logic             i_flush,
	input  logic             i_consume,
	input  cavlc_pkg::run_t  i_len,
	input  logic             i_bits_valid,
	input  logic [15:0]      i_bits,
	output logic             o_bits_req,
	output logic [15:0]      o_win_top,
	output logic             o_win_ok
);
	import cavlc_pkg::*;

	localparam int WIN_W  = `CAVLC_WIN_W;
	localparam int WORD_W = WIN_W / 2;
	localparam int FILL_W = $clog2(WIN_W + 1);

	logic [WIN_W-1:0]  win_q;
	logic [WIN_W-1:0]  win_base;
	logic [WIN_W-1:0]  win_next;
	logic [FILL_W-1:0] fill_q;
	logic [FILL_W-1:0] fill_base;
	logic [FILL_W-1:0] fill_next;
	logic              pend_q;

	// valid bits sit left aligned, zeros below them
	always_comb begin
		win_base  = win_q;
		fill_base = fill_q;
		if (i_flush) begin
			win_base  = '0;
			fill_base = '0;
		end else if (i_consume) begin
			win_base  = win_q << i_len;
			fill_base = fill_q - FILL_W'(i_len);
		end
		win_next  = win_base;
		fill_next = fill_base;
		// a new word goes right below the remaining valid bits
		if (i_bits_valid) begin
			win_next  = win_base | ({i_bits, {WORD_W{1'b0}}} >> fill_base);
			fill_next = fill_base + FILL_W'(WORD_W);
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			win_q  <= '0;
			fill_q <= '0;
			pend_q <= 1'b0;
		end else begin
			win_q  <= win_next;
			fill_q <= fill_next;
			// one word outstanding at a time
			if (i_bits_valid)
				pend_q <= 1'b0;
			else if (o_bits_req)
				pend_q <= 1'b1;
		end
	end

	assign o_bits_req = (fill_q < FILL_W'(WORD_W)) && !pend_q;
	assign o_win_top  = win_q[WIN_W-1 -: WORD_W];
	assign o_win_ok   = (fill_q >= FILL_W'(WORD_W));

	a_consume_in_fill: assert property (@(posedge clk) disable iff (!reset_n)
		i_consume && !i_flush |-> FILL_W'(i_len) <= fill_q)
		else $error("consume of %0d bits with only %0d in window", i_len, fill_q);

endmodule

`default_nettype wire

/* hdl/run_before_decoder.sv */
// run_before decoder, Table 9-10
`default_nettype none

`include "cavlc_defines.svh"

module run_before_decoder (
	input  logic                  clk,
	input  logic                  reset_n,
	input  cavlc_pkg::seq_state_t i_state,
	input  cavlc_pkg::run_t       i_total_zeros,
	input  logic [15:0]           i_win_top,
	input  logic                  i_win_ok,
	input  cavlc_pkg::pos_t       i_run_idx,
	input  cavlc_pkg::pos_t       i_rd_run_idx,
	output logic                  o_consume,
	output cavlc_pkg::run_t       o_len,
	output cavlc_pkg::run_t       o_zeros_left,
	output cavlc_pkg::run_t       o_run
);
	import cavlc_pkg::*;

	run_t zeros_left;
	run_t len_q;
	run_t run_q;
	run_t lut_len;
	run_t lut_run;
	logic lut_hit;
	run_t runs [`CAVLC_NCOEF];

	//------------------------------------------------------------
	// code length and run_before from the window top
	//------------------------------------------------------------
	always_comb begin
		lut_len = '0;
		lut_run = '0;
		lut_hit = 1'b0;
		case (zeros_left)
			4'd0: begin
				// nothing left, no bits taken
				lut_len = '0;
			end
			4'd1: begin
				lut_len = 4'd1;
				lut_run = i_win_top[15] ? 4'd0 : 4'd1;
			end
			4'd2: begin
				lut_len = i_win_top[15] ? 4'd1 : 4'd2;
				if (i_win_top[15])
					lut_run = 4'd0;
				else
					lut_run = i_win_top[14] ? 4'd1 : 4'd2;
			end
			4'd3: begin
				lut_len = 4'd2;
				lut_run = 4'd3 - {2'b00, i_win_top[15:14]};
			end
			4'd4: begin
				if (i_win_top[15:14] != 2'b00) begin
					lut_len = 4'd2;
					lut_run = 4'd3 - {2'b00, i_win_top[15:14]};
				end else begin
					lut_len = 4'd3;
					lut_run = i_win_top[13] ? 4'd3 : 4'd4;
				end
			end
			4'd5: begin
				lut_len = i_win_top[15] ? 4'd2 : 4'd3;
				case (i_win_top[15:14])
					2'b11: lut_run = 4'd0;
					2'b10: lut_run = 4'd1;
					2'b01: lut_run = i_win_top[13] ? 4'd2 : 4'd3;
					default: lut_run = i_win_top[13] ? 4'd4 : 4'd5;
				endcase
			end
			4'd6: begin
				lut_len = (i_win_top[15:14] == 2'b11) ? 4'd2 : 4'd3;
				case (i_win_top[15:13])
					3'b000: lut_run = 4'd1;
					3'b001: lut_run = 4'd2;
					3'b011: lut_run = 4'd3;
					3'b010: lut_run = 4'd4;
					3'b101: lut_run = 4'd5;
					3'b100: lut_run = 4'd6;
					default: lut_run = 4'd0;
				endcase
			end
			default: begin
				// zeros_left above 6 share one column
				if (i_win_top[15:13] != 3'b000) begin
					lut_len = 4'd3;
					lut_run = 4'd7 - {1'b0, i_win_top[15:13]};
				end else begin
					// unary tail, 0001 is run 7
					for (int k = 12; k >= 5; k--) begin
						if (!lut_hit && i_win_top[k]) begin
							lut_hit = 1'b1;
							lut_len = run_t'(16 - k);
							lut_run = run_t'(19 - k);
						end
					end
				end
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			zeros_left <= '0;
			len_q      <= '0;
			run_q      <= '0;
		end else begin
			case (i_state)
				S_IDLE, S_DONE: zeros_left <= i_total_zeros;
				S_RUN_LUT: begin
					if (i_win_ok) begin
						len_q <= lut_len;
						run_q <= lut_run;
					end
				end
				S_RUN_SHIFT: zeros_left <= zeros_left - run_q;
				default: ;
			endcase
		end
	end

	// one run per coefficient, last one takes what is left
	always_ff @(posedge clk) begin
		case (i_state)
			S_CLEAR:     runs <= '{default: '0};
			S_RUN_SHIFT: runs[i_run_idx] <= run_q;
			S_LAST_RUN:  runs[i_run_idx] <= zeros_left;
			default: ;
		endcase
	end

	assign o_consume    = (i_state == S_RUN_SHIFT);
	assign o_len        = len_q;
	assign o_zeros_left = zeros_left;
	assign o_run        = runs[i_rd_run_idx];

	a_run_in_zeros: assert property (@(posedge clk) disable iff (!reset_n)
		(i_state == S_RUN_SHIFT) |-> run_q <= zeros_left)
		else $error("run_before %0d beyond zeros_left %0d", run_q, zeros_left);

endmodule

`default_nettype wire

/* hdl/run_sequencer.sv */
// Block sequencer FSM
`default_nettype none

module run_sequencer (
	input  logic                  clk,
	input  logic                  reset_n,
	input  logic                  i_start,
	input  cavlc_pkg::tcoef_t     i_total_coeff,
	input  cavlc_pkg::run_t       i_zeros_left,
	input  logic                  i_win_ok,
	input  logic                  i_clear_done,
	input  logic                  i_place_done,
	output cavlc_pkg::seq_state_t o_state,
	output cavlc_pkg::pos_t       o_run_idx,
	output logic                  o_busy,
	output logic                  o_done
);
	import cavlc_pkg::*;

	seq_state_t state_q;
	tcoef_t     tc_q;
	pos_t       run_idx_q;
	logic       last_pair;

	// index TotalCoeff-2 is the last decoded run
	assign last_pair = ({1'b0, run_idx_q} == tc_q - 5'd2);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state_q   <= S_IDLE;
			tc_q      <= '0;
			run_idx_q <= '0;
		end else begin
			case (state_q)
				S_IDLE, S_DONE: begin
					if (i_start) begin
						tc_q      <= i_total_coeff;
						run_idx_q <= '0;
						state_q   <= S_CLEAR;
					end else begin
						state_q <= S_IDLE;
					end
				end
				S_CLEAR: begin
					if (i_clear_done) begin
						if (tc_q == '0)
							state_q <= S_DONE;
						else if (tc_q == 5'd1)
							state_q <= S_LAST_RUN;
						else
							state_q <= S_RUN_LUT;
					end
				end
				S_RUN_LUT: begin
					// no zeros left, later runs stay 0
					if (i_zeros_left == '0)
						state_q <= S_LAST_RUN;
					else if (i_win_ok)
						state_q <= S_RUN_SHIFT;
				end
				S_RUN_SHIFT: begin
					run_idx_q <= run_idx_q + 4'd1;
					state_q   <= last_pair ? S_LAST_RUN : S_RUN_LUT;
				end
				S_LAST_RUN: state_q <= S_PLACE;
				S_PLACE: begin
					if (i_place_done)
						state_q <= S_DONE;
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

	assign o_state   = state_q;
	assign o_run_idx = run_idx_q;
	assign o_busy    = (state_q != S_IDLE) && (state_q != S_DONE);
	assign o_done    = (state_q == S_DONE);

endmodule

`default_nettype wire

/* hdl/coeff_placer.sv */
// Coefficient clear and placement
`default_nettype none

`include "cavlc_defines.svh"

module coeff_placer (
	input  logic                  clk,
	input  logic                  reset_n,
	input  cavlc_pkg::seq_state_t i_state,
	input  cavlc_pkg::tcoef_t     i_total_coeff,
	input  logic                  i_lvl_wr,
	input  cavlc_pkg::pos_t       i_lvl_idx,
	input  cavlc_pkg::level_t     i_lvl_data,
	input  cavlc_pkg::run_t       i_run,
	output cavlc_pkg::pos_t       o_rd_run_idx,
	output logic                  o_clear_done,
	output logic                  o_place_done,
	mem_port_if.master            mem
);
	import cavlc_pkg::*;

	level_t levels [`CAVLC_NCOEF];
	tcoef_t tc_q;
	pos_t   clr_cnt_q;
	pos_t   idx_q;
	pos_t   pos_q;
	pos_t   place_pos;
	logic   in_clear;
	logic   in_place;

	assign in_clear = (i_state == S_CLEAR);
	assign in_place = (i_state == S_PLACE);

	// next position is one past the zeros of this run
	assign place_pos = pos_q + i_run + 4'd1;

	assign mem.req   = in_clear || in_place;
	assign mem.we    = in_clear || in_place;
	assign mem.addr  = in_clear ? clr_cnt_q : place_pos;
	assign mem.wdata = in_clear ? level_t'('0) : levels[idx_q];

	assign o_rd_run_idx = idx_q;
	assign o_clear_done = in_clear && mem.gnt && (clr_cnt_q == pos_t'(`CAVLC_NCOEF - 1));
	assign o_place_done = in_place && mem.gnt && (idx_q == '0);

	always_ff @(posedge clk) begin
		if (i_lvl_wr)
			levels[i_lvl_idx] <= i_lvl_data;
	end

	//------------------------------------------------------------
	// walk from the lowest-frequency level down to level 0
	//------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			tc_q      <= '0;
			clr_cnt_q <= '0;
			idx_q     <= '0;
			pos_q     <= '0;
		end else begin
			if (i_state == S_IDLE || i_state == S_DONE) begin
				tc_q      <= i_total_coeff;
				clr_cnt_q <= '0;
			end
			if (in_clear && mem.gnt)
				clr_cnt_q <= clr_cnt_q + 4'd1;
			// position starts at -1
			if (i_state == S_LAST_RUN) begin
				idx_q <= pos_t'(tc_q - 5'd1);
				pos_q <= '1;
			end
			if (in_place && mem.gnt) begin
				pos_q <= place_pos;
				idx_q <= idx_q - 4'd1;
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/coeff_store_arb.sv */
// Coefficient store and arbiter
`default_nettype none

`include "cavlc_defines.svh"

module coeff_store_arb (
	input  logic       clk,
	input  logic       reset_n,
	mem_port_if.slave  place,
	mem_port_if.slave  rd
);
	import cavlc_pkg::*;

	level_t store [`CAVLC_NCOEF];
	level_t rdata_q;
	logic   rd_pend_q;
	pos_t   rd_addr_q;
	logic   rd_gnt;
	pos_t   rd_sel;
	logic   wr_en;
	pos_t   wr_addr;
	level_t wr_data;

	// placer always wins
	assign place.gnt = place.req;
	assign rd_gnt    = (rd_pend_q || rd.req) && !place.req;
	assign rd.gnt    = rd_gnt;
	assign rd_sel    = rd_pend_q ? rd_addr_q : rd.addr;

	// a direct write from the second port only when it is granted at once
	assign wr_en   = place.req ? place.we : (rd_gnt && !rd_pend_q && rd.we);
	assign wr_addr = place.req ? place.addr : rd.addr;
	assign wr_data = place.req ? place.wdata : rd.wdata;

	assign place.rdata = rdata_q;
	assign rd.rdata    = rdata_q;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			store <= '{default: '0};
		end else begin
			if (wr_en)
				store[wr_addr] <= wr_data;
			if (rd_gnt)
				rdata_q <= store[rd_sel];
		end
	end

	//------------------------------------------------------------
	// a read that loses waits here for the next free cycle
	//------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			rd_pend_q <= 1'b0;
			rd_addr_q <= '0;
		end else begin
			if (rd_gnt)
				rd_pend_q <= 1'b0;
			else if (rd.req && !rd.we)
				rd_pend_q <= 1'b1;
			if (rd.req && !rd_pend_q)
				rd_addr_q <= rd.addr;
		end
	end

	// the read side issues no new request while one waits
	a_no_req_on_pend: assert property (@(posedge clk) disable iff (!reset_n)
		rd_pend_q |-> !rd.req)
		else $error("read request while an earlier read is still pending");

endmodule

`default_nettype wire

/* hdl/cavlc_run_top.sv */
// CAVLC run decoder top
`default_nettype none

module cavlc_run_top (
	input  logic              clk,
	input  logic              reset_n,
	input  logic              i_lvl_wr,
	input  cavlc_pkg::pos_t   i_lvl_idx,
	input  cavlc_pkg::level_t i_lvl_data,
	input  logic              i_start,
	input  cavlc_pkg::tcoef_t i_total_coeff,
	input  cavlc_pkg::run_t   i_total_zeros,
	input  logic              i_bits_valid,
	input  logic [15:0]       i_bits,
	input  logic              i_rd_en,
	input  cavlc_pkg::pos_t   i_rd_addr,
	output logic              o_bits_req,
	output logic              o_busy,
	output logic              o_done,
	output logic              o_rd_valid,
	output cavlc_pkg::level_t o_rd_data
);
	import cavlc_pkg::*;

	seq_state_t  seq_state;
	pos_t        run_idx;
	pos_t        rd_run_idx;
	run_t        zeros_left;
	run_t        code_len;
	run_t        run_val;
	logic        consume;
	logic        win_ok;
	logic        clear_done;
	logic        place_done;
	logic        flush;
	logic [15:0] win_top;

	mem_port_if #(.payload_t(level_t)) place_if ();
	mem_port_if #(.payload_t(level_t)) rd_if ();

	// start is only taken while idle
	assign flush = i_start && !o_busy;

	// read strobe in, valid one cycle after the grant
	assign rd_if.req   = i_rd_en;
	assign rd_if.we    = 1'b0;
	assign rd_if.addr  = i_rd_addr;
	assign rd_if.wdata = '0;
	assign o_rd_data   = rd_if.rdata;

	always_ff @(posedge clk) begin
		if (!reset_n)
			o_rd_valid <= 1'b0;
		else
			o_rd_valid <= rd_if.gnt;
	end

	bit_window bit_window_inst (
		.clk          (clk),
		.reset_n      (reset_n),
		.i_flush      (flush),
		.i_consume    (consume),
		.i_len        (code_len),
		.i_bits_valid (i_bits_valid),
		.i_bits       (i_bits),
		.o_bits_req   (o_bits_req),
		.o_win_top    (win_top),
		.o_win_ok     (win_ok)
	);

	run_before_decoder run_before_decoder_inst (
		.clk           (clk),
		.reset_n       (reset_n),
		.i_state       (seq_state),
		.i_total_zeros (i_total_zeros),
		.i_win_top     (win_top),
		.i_win_ok      (win_ok),
		.i_run_idx     (run_idx),
		.i_rd_run_idx  (rd_run_idx),
		.o_consume     (consume),
		.o_len         (code_len),
		.o_zeros_left  (zeros_left),
		.o_run         (run_val)
	);

	run_sequencer run_sequencer_inst (
		.clk           (clk),
		.reset_n       (reset_n),
		.i_start       (i_start),
		.i_total_coeff (i_total_coeff),
		.i_zeros_left  (zeros_left),
		.i_win_ok      (win_ok),
		.i_clear_done  (clear_done),
		.i_place_done  (place_done),
		.o_state       (seq_state),
		.o_run_idx     (run_idx),
		.o_busy        (o_busy),
		.o_done        (o_done)
	);

	coeff_placer coeff_placer_inst (
		.clk           (clk),
		.reset_n       (reset_n),
		.i_state       (seq_state),
		.i_total_coeff (i_total_coeff),
		.i_lvl_wr      (i_lvl_wr),
		.i_lvl_idx     (i_lvl_idx),
		.i_lvl_data    (i_lvl_data),
		.i_run         (run_val),
		.o_rd_run_idx  (rd_run_idx),
		.o_clear_done  (clear_done),
		.o_place_done  (place_done),
		.mem           (place_if.master)
	);

	coeff_store_arb coeff_store_arb_inst (
		.clk     (clk),
		.reset_n (reset_n),
		.place   (place_if.slave),
		.rd      (rd_if.slave)
	);

endmodule

`default_nettype wire

/* tb/tb_ref_model.svh */
// Testbench reference model
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// 16-bit Fibonacci LFSR, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
	logic fb;
	fb = s[15] ^ s[13] ^ s[12] ^ s[10];
	return {s[14:0], fb};
endfunction

// one LFSR step per bit taken
function automatic int rand_bits(input int n);
	int v;
	v = 0;
	for (int i = 0; i < n; i++) begin
		lfsr_q = lfsr_next(lfsr_q);
		v = (v << 1) | int'(lfsr_q[0]);
	end
	return v;
endfunction

//------------------------------------------------------------
// run_before code words, Table 9-10
//------------------------------------------------------------
function automatic void run_code(input int zl, input int run, output int len, output int bits);
	len  = 3;
	bits = 0;
	case (zl)
		1: begin
			len  = 1;
			bits = (run == 0) ? 1 : 0;
		end
		2: begin
			len  = (run == 0) ? 1 : 2;
			bits = (run == 2) ? 0 : 1;
		end
		3: begin
			len  = 2;
			bits = 3 - run;
		end
		4: begin
			len  = (run < 3) ? 2 : 3;
			bits = (run < 3) ? 3 - run : 4 - run;
		end
		5: begin
			len  = (run < 2) ? 2 : 3;
			bits = (run < 2) ? 3 - run : 5 - run;
		end
		6: begin
			case (run)
				0: begin
					len  = 2;
					bits = 3;
				end
				1: bits = 0;
				2: bits = 1;
				3: bits = 3;
				4: bits = 2;
				5: bits = 5;
				default: bits = 4;
			endcase
		end
		default: begin
			// long runs become a string of zeros closed by a one
			len  = (run < 7) ? 3 : run - 3;
			bits = (run < 7) ? 7 - run : 1;
		end
	endcase
endfunction

// expected coefficient at one scan position
function automatic int ref_coeff(input int tc, input int pos);
	int p;
	int v;
	p = -1;
	v = 0;
	for (int i = tc - 1; i >= 0; i--) begin
		p = p + blk_run[i] + 1;
		if (p == pos)
			v = blk_lvl[i];
	end
	return v;
endfunction

`endif

/* tb/tb_cavlc_run.sv */
// CAVLC run decoder testbench
`default_nettype none

module tb_cavlc_run;
	import cavlc_pkg::*;

	localparam int N_TESTS        = 40;
	localparam int CYC_PER_TEST   = 200;
	localparam int TIMEOUT_CYCLES = N_TESTS * CYC_PER_TEST;

	logic        clk;
	logic        reset_n;
	logic        i_lvl_wr;
	pos_t        i_lvl_idx;
	level_t      i_lvl_data;
	logic        i_start;
	tcoef_t      i_total_coeff;
	run_t        i_total_zeros;
	logic        i_bits_valid;
	logic [15:0] i_bits;
	logic        i_rd_en;
	pos_t        i_rd_addr;
	logic        o_bits_req;
	logic        o_busy;
	logic        o_done;
	logic        o_rd_valid;
	level_t      o_rd_data;

	logic [15:0] lfsr_q = 16'd42045;
	int          blk_lvl [16];
	int          blk_run [16];
	logic        bitq [$];
	int          exp_q [$];
	int          addr_q [$];
	int          feed_wait = -1;
	int          feed_slow = 0;
	int          req_cnt = 0;
	int          rd_issued = 0;
	int          rd_seen = 0;
	int          err_cnt = 0;
	int          pass_cnt = 0;
	int          fail_cnt = 0;
	int          test_no = 0;
	int          cycle_cnt = 0;

	`include "tb_ref_model.svh"

	cavlc_run_top cavlc_run_top_inst (
		.clk           (clk),
		.reset_n       (reset_n),
		.i_lvl_wr      (i_lvl_wr),
		.i_lvl_idx     (i_lvl_idx),
		.i_lvl_data    (i_lvl_data),
		.i_start       (i_start),
		.i_total_coeff (i_total_coeff),
		.i_total_zeros (i_total_zeros),
		.i_bits_valid  (i_bits_valid),
		.i_bits        (i_bits),
		.i_rd_en       (i_rd_en),
		.i_rd_addr     (i_rd_addr),
		.o_bits_req    (o_bits_req),
		.o_busy        (o_busy),
		.o_done        (o_done),
		.o_rd_valid    (o_rd_valid),
		.o_rd_data     (o_rd_data)
	);

	always #50 clk = ~clk;

	always @(posedge clk)
		cycle_cnt <= cycle_cnt + 1;

	initial begin
		wait (cycle_cnt >= TIMEOUT_CYCLES);
		$display("timeout after %0d cycles, the DUT stopped making progress", cycle_cnt);
		$display("STATUS: FAIL");
		$finish;
	end

	//------------------------------------------------------------
	// bitstream feeder, answers each request after a delay
	//------------------------------------------------------------
	task automatic feed();
		logic [15:0] word;
		begin
			if (reset_n) begin
				if (feed_wait < 0 && o_bits_req) begin
					req_cnt++;
					feed_wait = feed_slow ? 8 + rand_bits(3) : rand_bits(2);
				end
				if (feed_wait == 0) begin
					// past the end of the block the stream is zero padded
					for (int k = 15; k >= 0; k--)
						word[k] = (bitq.size() > 0) ? bitq.pop_front() : 1'b0;
					i_bits       = word;
					i_bits_valid = 1'b1;
					feed_wait    = -1;
				end else if (feed_wait > 0) begin
					feed_wait--;
				end
			end
		end
	endtask

	// strobes set before this call last for one rising edge
	task automatic tick();
		begin
			feed();
			@(negedge clk);
			i_start      = 1'b0;
			i_lvl_wr     = 1'b0;
			i_rd_en      = 1'b0;
			i_bits_valid = 1'b0;
		end
	endtask

	task automatic read_entry(input int addr, input int exp);
		begin
			i_rd_en   = 1'b1;
			i_rd_addr = pos_t'(addr);
			exp_q.push_back(exp);
			addr_q.push_back(addr);
			rd_issued++;
			tick();
			while (rd_seen < rd_issued)
				tick();
		end
	endtask

	//------------------------------------------------------------
	// compare read data against the reference
	//------------------------------------------------------------
	always @(negedge clk) begin : compare_reads
		int got;
		int exp;
		int addr;
		if (o_rd_valid) begin
			assert (exp_q.size() != 0)
			else begin
				$display("read data returned at %0t with no read outstanding", $time);
				err_cnt++;
			end
			if (exp_q.size() != 0) begin
				exp  = exp_q.pop_front();
				addr = addr_q.pop_front();
				got  = int'(o_rd_data);
				assert (got == exp)
				else begin
					$display("ERROR t=%0t o_rd_data[%0d] expected %0d got %0d",
						$time, addr, exp, got);
					err_cnt++;
				end
				rd_seen++;
			end
		end
	end

	// mode 0 random runs, 1 unit runs, 2 whole remainder in one run
	task automatic run_block(input int tc, input int tz, input int mode, input int slow,
			input int rd_place);
		int zl;
		int r;
		int len;
		int bits;
		int a;
		int v;
		bit done_seen;
		bit rd_sent;
		begin
			zl = tz;
			bitq.delete();
			for (int i = 0; i < 16; i++)
				blk_run[i] = 0;
			for (int i = 0; i < tc; i++) begin
				v = rand_bits(9) - 256;
				if (v == 0)
					v = 1;
				blk_lvl[i] = v;
				i_lvl_wr   = 1'b1;
				i_lvl_idx  = pos_t'(i);
				i_lvl_data = level_t'(v);
				tick();
			end
			// codes only while zeros remain, the last run is implied
			for (int i = 0; i < tc - 1 && zl > 0; i++) begin
				if (mode == 1)
					r = 1;
				else if (mode == 2)
					r = zl;
				else
					r = rand_bits(8) % (zl + 1);
				run_code(zl, r, len, bits);
				for (int b = len - 1; b >= 0; b--)
					bitq.push_back(bits[b]);
				blk_run[i] = r;
				zl = zl - r;
			end
			blk_run[tc - 1] = zl;
			feed_slow     = slow;
			req_cnt       = 0;
			i_start       = 1'b1;
			i_total_coeff = tcoef_t'(tc);
			i_total_zeros = run_t'(tz);
			tick();
			assert (o_busy == 1'b1)
			else begin
				$display("ERROR t=%0t o_busy expected 1 got %0b", $time, o_busy);
				err_cnt++;
			end
			done_seen = 1'b0;
			rd_sent   = 1'b0;
			while (!done_seen || rd_seen < rd_issued) begin
				if (rd_place != 0 && !rd_sent &&
						cavlc_run_top_inst.seq_state == S_PLACE) begin
					// held until the placer stops, so the entry is already final
					a         = rand_bits(4);
					i_rd_en   = 1'b1;
					i_rd_addr = pos_t'(a);
					exp_q.push_back(ref_coeff(tc, a));
					addr_q.push_back(a);
					rd_issued++;
					rd_sent = 1'b1;
				end
				tick();
				if (o_done) begin
					done_seen = 1'b1;
					// busy drops together with the done pulse
					assert (o_busy == 1'b0)
					else begin
						$display("ERROR t=%0t o_busy expected 0 got %0b", $time, o_busy);
						err_cnt++;
					end
				end
			end
			for (a = 0; a < 16; a++)
				read_entry(a, ref_coeff(tc, a));
		end
	endtask

	task automatic end_test(input string name, input int err_before);
		begin
			test_no++;
			if (err_cnt == err_before) begin
				pass_cnt++;
				$display("test %0d %s: passed", test_no, name);
			end else begin
				fail_cnt++;
				$display("test %0d %s: failed, %0d errors", test_no, name, err_cnt - err_before);
			end
		end
	endtask

	//------------------------------------------------------------
	// test sequence
	//------------------------------------------------------------
	initial begin : main_seq
		int e0;
		int tc;
		int tz;
		int lim;
		clk           = 1'b0;
		reset_n       = 1'b0;
		i_lvl_wr      = 1'b0;
		i_lvl_idx     = '0;
		i_lvl_data    = '0;
		i_start       = 1'b0;
		i_total_coeff = '0;
		i_total_zeros = '0;
		i_bits_valid  = 1'b0;
		i_bits        = '0;
		i_rd_en       = 1'b0;
		i_rd_addr     = '0;
		repeat (4) @(negedge clk);
		reset_n = 1'b1;

		e0 = err_cnt;
		assert (o_busy == 1'b0 && o_done == 1'b0)
		else begin
			$display("ERROR t=%0t o_busy/o_done expected 0/0 got %0b/%0b", $time, o_busy, o_done);
			err_cnt++;
		end
		// the empty window asks for one word first
		repeat (6) tick();
		assert (o_bits_req == 1'b0)
		else begin
			$display("ERROR t=%0t o_bits_req expected 0 got %0b", $time, o_bits_req);
			err_cnt++;
		end
		for (int a = 0; a < 16; a++)
			read_entry(a, 0);
		end_test("reset state", e0);

		for (int n = 0; n < 3; n++) begin
			e0 = err_cnt;
			run_block(1, rand_bits(4), 0, 0, 0);
			end_test("single coefficient", e0);
		end

		e0 = err_cnt;
		run_block(9, 7, 1, 0, 0);
		end_test("unit runs over all columns", e0);
		e0 = err_cnt;
		run_block(2, 14, 2, 0, 0);
		end_test("longest run_before code", e0);
		e0 = err_cnt;
		run_block(4, 12, 2, 0, 0);
		end_test("early zeros_left exit", e0);
		for (int n = 0; n < 16; n++) begin
			e0  = err_cnt;
			tc  = rand_bits(4) + 1;
			lim = (16 - tc > 15) ? 15 : 16 - tc;
			tz  = rand_bits(4) % (lim + 1);
			run_block(tc, tz, 0, 0, 0);
			end_test("random block", e0);
		end

		for (int n = 0; n < 3; n++) begin
			e0 = err_cnt;
			run_block(2 + rand_bits(4) % 15, 0, 0, 0, 0);
			assert (req_cnt == 1)
			else begin
				$display("window asked for %0d words with no zeros, only the first fill expected",
					req_cnt);
				err_cnt++;
			end
			end_test("no zeros", e0);
		end

		for (int n = 0; n < 4; n++) begin
			e0 = err_cnt;
			tc = 2 + rand_bits(3);
			run_block(tc, 16 - tc - rand_bits(1), 0, 1, 0);
			end_test("starved bitstream", e0);
		end

		for (int n = 0; n < 2; n++) begin
			e0 = err_cnt;
			tc = 4 + rand_bits(3);
			run_block(tc, rand_bits(4) % (17 - tc), 0, 0, 1);
			end_test("read during placement", e0);
		end

		$display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0 && err_cnt == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+hdl
+incdir+tb
hdl/cavlc_pkg.sv
hdl/mem_port_if.sv
hdl/bit_window.sv
hdl/run_before_decoder.sv
hdl/run_sequencer.sv
hdl/coeff_placer.sv
hdl/coeff_store_arb.sv
hdl/cavlc_run_top.sv
tb/tb_cavlc_run.sv

/* run_sim.sh */
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -f vlog.f --top-module tb_cavlc_run -o sim_tb \
	&& ./obj_dir/sim_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "STATUS: PASS" sim.log || exit 1
